//--- source/mips_pkg.sv
// shared types for the five-stage core; only the opcodes and functs listed here are decoded.
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [5:0] {
        op_rtype = 6'b000000,
        op_j     = 6'b000010,
        op_beq   = 6'b000100,
        op_addi  = 6'b001000,
        op_lw    = 6'b100011,
        op_sw    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        funct_add = 6'b100000,
        funct_sub = 6'b100010,
        funct_and = 6'b100100,
        funct_or  = 6'b100101,
        funct_slt = 6'b101010
    } funct_e;

    typedef enum logic [2:0] {
        alu_and = 3'b000,
        alu_or  = 3'b001,
        alu_add = 3'b010,
        alu_nop = 3'b101,
        alu_sub = 3'b110,
        alu_slt = 3'b111
    } alu_op_e;

    // the immediate and the jump address overlay the low 16 and 26 bits.
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_write;
        logic    alu_src;    // second ALU operand is the immediate.
        logic    reg_dst;    // destination is rd, otherwise rt.
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     opnd_a;
        word_t     opnd_b;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } de_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_write;
        word_t     alu_out;
        word_t     write_data;
        reg_addr_t dest;
    } em_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_out;
        word_t     read_data;
        reg_addr_t dest;
    } mw_t;

    typedef enum logic [1:0] {
        fwd_reg = 2'b00,
        fwd_wb  = 2'b01,
        fwd_mem = 2'b10
    } fwd_sel_e;

endpackage

//--- source/mips_fetch.sv
`timescale 1ns/100ps
// instruction memory must answer combinationally; redirect is expected to be low while stalled.
module mips_fetch #(
    parameter mips_pkg::word_t reset_pc = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              redirect,
    input  mips_pkg::word_t   target,
    input  mips_pkg::word_t   instr,
    output mips_pkg::word_t   pc,
    output mips_pkg::instr_t  instr_d,
    output mips_pkg::word_t   pc_plus4_d
);

    mips_pkg::word_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (!stall) begin
            pc <= redirect ? target : pc_plus4;
        end
    end

    // the word fetched behind a taken branch or jump is squashed to a nop.
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            instr_d    <= '0;
            pc_plus4_d <= '0;
        end else if (!stall) begin
            instr_d    <= mips_pkg::instr_t'(instr);
            pc_plus4_d <= pc_plus4;
        end
    end

endmodule

//--- source/mips_decode.sv
`timescale 1ns/100ps
// register 0 is hardwired to zero; beq operands must be settled, the hazard unit stalls until they are.
module mips_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  mips_pkg::instr_t    instr_d,
    input  mips_pkg::word_t     pc_plus4_d,
    input  logic                fwd_a_d,
    input  logic                fwd_b_d,
    input  mips_pkg::word_t     alu_out_m,
    input  logic                wb_write,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    output logic                redirect,
    output mips_pkg::word_t     target,
    output logic                branch_d,
    output mips_pkg::de_t       de
);

    mips_pkg::word_t  regs [32];
    mips_pkg::word_t  rd1;
    mips_pkg::word_t  rd2;
    mips_pkg::word_t  opnd_a;
    mips_pkg::word_t  opnd_b;
    mips_pkg::word_t  imm;
    mips_pkg::word_t  branch_target;
    mips_pkg::word_t  jump_target;
    mips_pkg::ctrl_t  ctrl;
    mips_pkg::de_t    de_next;
    logic             jump_d;
    logic             equal_d;

    // main decoder; unknown opcodes and functs leave all enables low.
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = mips_pkg::alu_nop;
        branch_d    = 1'b0;
        jump_d      = 1'b0;
        case (instr_d.opcode)
            mips_pkg::op_rtype: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (instr_d.funct)
                    mips_pkg::funct_add: ctrl.alu_op = mips_pkg::alu_add;
                    mips_pkg::funct_sub: ctrl.alu_op = mips_pkg::alu_sub;
                    mips_pkg::funct_and: ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::funct_or:  ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::funct_slt: ctrl.alu_op = mips_pkg::alu_slt;
                    default:             ctrl.reg_write = 1'b0;
                endcase
            end
            mips_pkg::op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = mips_pkg::alu_add;
            end
            mips_pkg::op_sw: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = mips_pkg::alu_add;
            end
            mips_pkg::op_addi: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = mips_pkg::alu_add;
            end
            mips_pkg::op_beq: branch_d = 1'b1;
            mips_pkg::op_j:   jump_d   = 1'b1;
            default: ;
        endcase
    end

    // writes land on the rising edge; same-cycle reads see them through the bypass.
    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[wb_reg] <= wb_data;
        end
    end

    assign rd1 = (instr_d.rs == '0) ? '0 :
                 (wb_write && wb_reg == instr_d.rs) ? wb_data : regs[instr_d.rs];
    assign rd2 = (instr_d.rt == '0) ? '0 :
                 (wb_write && wb_reg == instr_d.rt) ? wb_data : regs[instr_d.rt];

    assign opnd_a = fwd_a_d ? alu_out_m : rd1;   // result still in the memory stage.
    assign opnd_b = fwd_b_d ? alu_out_m : rd2;

    assign imm           = {{16{instr_d[15]}}, instr_d[15:0]};
    assign branch_target = pc_plus4_d + {imm[29:0], 2'b00};
    assign jump_target   = {pc_plus4_d[31:28], instr_d[25:0], 2'b00};
    assign equal_d       = (opnd_a == opnd_b);

    // a stalled branch may be comparing stale operands, so it must wait.
    assign redirect = !stall && ((branch_d && equal_d) || jump_d);
    assign target   = jump_d ? jump_target : branch_target;

    always_comb begin
        de_next.ctrl   = ctrl;
        de_next.opnd_a = opnd_a;
        de_next.opnd_b = opnd_b;
        de_next.imm    = imm;
        de_next.rs     = instr_d.rs;
        de_next.rt     = instr_d.rt;
        de_next.rd     = instr_d.rd;
    end

    always_ff @(posedge clk) begin
        if (rst || stall) begin
            de <= '0;   // a bubble goes down the pipe.
        end else begin
            de <= de_next;
        end
    end

endmodule

//--- source/mips_execute.sv
`timescale 1ns/100ps
// data memory must return read_data combinationally for the address on alu_out.
module mips_execute (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::de_t       de,
    input  mips_pkg::fwd_sel_e  fwd_a_e,
    input  mips_pkg::fwd_sel_e  fwd_b_e,
    input  mips_pkg::word_t     read_data,
    output mips_pkg::word_t     alu_out,
    output mips_pkg::word_t     write_data,
    output logic                mem_write,
    output mips_pkg::em_t       em_ctrl,
    output mips_pkg::word_t     alu_out_m,
    output logic                wb_write,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data
);

    mips_pkg::em_t       em;
    mips_pkg::mw_t       mw;
    mips_pkg::word_t     src_a;
    mips_pkg::word_t     fwd_b;
    mips_pkg::word_t     src_b;
    mips_pkg::word_t     alu_y;
    mips_pkg::reg_addr_t dest_e;

    always_comb begin
        case (fwd_a_e)
            mips_pkg::fwd_mem: src_a = em.alu_out;
            mips_pkg::fwd_wb:  src_a = wb_data;
            default:           src_a = de.opnd_a;
        endcase
        case (fwd_b_e)
            mips_pkg::fwd_mem: fwd_b = em.alu_out;
            mips_pkg::fwd_wb:  fwd_b = wb_data;
            default:           fwd_b = de.opnd_b;
        endcase
    end

    assign src_b  = de.ctrl.alu_src ? de.imm : fwd_b;
    assign dest_e = de.ctrl.reg_dst ? de.rd : de.rt;

    always_comb begin
        case (de.ctrl.alu_op)
            mips_pkg::alu_add: alu_y = src_a + src_b;
            mips_pkg::alu_sub: alu_y = src_a - src_b;
            mips_pkg::alu_and: alu_y = src_a & src_b;
            mips_pkg::alu_or:  alu_y = src_a | src_b;
            // slt compares as two's complement.
            mips_pkg::alu_slt: alu_y = {31'b0, $signed(src_a) < $signed(src_b)};
            default:           alu_y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            em <= '0;
        end else begin
            em.reg_write  <= de.ctrl.reg_write;
            em.mem_to_reg <= de.ctrl.mem_to_reg;
            em.mem_write  <= de.ctrl.mem_write;
            em.alu_out    <= alu_y;
            em.write_data <= fwd_b;   // store data uses the forwarded rt value.
            em.dest       <= dest_e;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mw <= '0;
        end else begin
            mw.reg_write  <= em.reg_write;
            mw.mem_to_reg <= em.mem_to_reg;
            mw.alu_out    <= em.alu_out;
            mw.read_data  <= read_data;
            mw.dest       <= em.dest;
        end
    end

    assign alu_out    = em.alu_out;
    assign write_data = em.write_data;
    assign mem_write  = em.mem_write;
    assign em_ctrl    = em;
    assign alu_out_m  = em.alu_out;

    assign wb_write = mw.reg_write;
    assign wb_reg   = mw.dest;
    assign wb_data  = mw.mem_to_reg ? mw.read_data : mw.alu_out;

endmodule

//--- source/mips_hazard.sv
`timescale 1ns/100ps
// purely combinational; register 0 never forwards and never causes a stall.
module mips_hazard (
    input  mips_pkg::reg_addr_t rs_d,
    input  mips_pkg::reg_addr_t rt_d,
    input  logic                branch_d,
    input  mips_pkg::de_t       de,
    input  mips_pkg::em_t       em,
    input  logic                wb_write,
    input  mips_pkg::reg_addr_t wb_reg,
    output logic                stall,
    output logic                fwd_a_d,
    output logic                fwd_b_d,
    output mips_pkg::fwd_sel_e  fwd_a_e,
    output mips_pkg::fwd_sel_e  fwd_b_e
);

    mips_pkg::reg_addr_t dest_e;
    logic                hit_e;
    logic                hit_m;
    logic                load_stall;
    logic                branch_stall;

    assign dest_e = de.ctrl.reg_dst ? de.rd : de.rt;

    // decode only forwards from the memory stage, for the branch compare.
    assign fwd_a_d = (rs_d != '0) && em.reg_write && (rs_d == em.dest);
    assign fwd_b_d = (rt_d != '0) && em.reg_write && (rt_d == em.dest);

    // the memory stage holds the younger result and wins over write-back.
    assign fwd_a_e = ((de.rs != '0) && em.reg_write && (de.rs == em.dest)) ? mips_pkg::fwd_mem :
                     ((de.rs != '0) && wb_write && (de.rs == wb_reg)) ? mips_pkg::fwd_wb :
                     mips_pkg::fwd_reg;
    assign fwd_b_e = ((de.rt != '0) && em.reg_write && (de.rt == em.dest)) ? mips_pkg::fwd_mem :
                     ((de.rt != '0) && wb_write && (de.rt == wb_reg)) ? mips_pkg::fwd_wb :
                     mips_pkg::fwd_reg;

    assign load_stall = de.ctrl.mem_to_reg && (de.rt != '0) &&
                        ((rs_d == de.rt) || (rt_d == de.rt));

    assign hit_e = de.ctrl.reg_write && (dest_e != '0) &&
                   ((dest_e == rs_d) || (dest_e == rt_d));
    assign hit_m = em.mem_to_reg && (em.dest != '0) &&
                   ((em.dest == rs_d) || (em.dest == rt_d));

    // beq compares in decode, so any result not yet in the memory stage must arrive first.
    assign branch_stall = branch_d && (hit_e || hit_m);

    assign stall = load_stall || branch_stall;

endmodule

//--- source/mips_core.sv
`timescale 1ns/100ps
// memories are external and answer in the same cycle; a store is a one-cycle mem_write pulse.
module mips_core #(
    parameter mips_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  mips_pkg::word_t instr,
    input  mips_pkg::word_t read_data,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t alu_out,
    output mips_pkg::word_t write_data,
    output logic            mem_write
);

    mips_pkg::instr_t    instr_d;
    mips_pkg::word_t     pc_plus4_d;
    mips_pkg::word_t     target;
    mips_pkg::word_t     alu_out_m;
    mips_pkg::word_t     wb_data;
    mips_pkg::reg_addr_t wb_reg;
    mips_pkg::de_t       de;
    mips_pkg::em_t       em_ctrl;
    mips_pkg::fwd_sel_e  fwd_a_e;
    mips_pkg::fwd_sel_e  fwd_b_e;
    logic                stall;
    logic                redirect;
    logic                branch_d;
    logic                fwd_a_d;
    logic                fwd_b_d;
    logic                wb_write;

    mips_fetch #(
        .reset_pc(reset_pc)
    ) i_fetch (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .redirect   (redirect),
        .target     (target),
        .instr      (instr),
        .pc         (pc),
        .instr_d    (instr_d),
        .pc_plus4_d (pc_plus4_d)
    );

    mips_decode i_decode (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .instr_d    (instr_d),
        .pc_plus4_d (pc_plus4_d),
        .fwd_a_d    (fwd_a_d),
        .fwd_b_d    (fwd_b_d),
        .alu_out_m  (alu_out_m),
        .wb_write   (wb_write),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .redirect   (redirect),
        .target     (target),
        .branch_d   (branch_d),
        .de         (de)
    );

    mips_execute i_execute (
        .clk        (clk),
        .rst        (rst),
        .de         (de),
        .fwd_a_e    (fwd_a_e),
        .fwd_b_e    (fwd_b_e),
        .read_data  (read_data),
        .alu_out    (alu_out),
        .write_data (write_data),
        .mem_write  (mem_write),
        .em_ctrl    (em_ctrl),
        .alu_out_m  (alu_out_m),
        .wb_write   (wb_write),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

    mips_hazard i_hazard (
        .rs_d     (instr_d.rs),
        .rt_d     (instr_d.rt),
        .branch_d (branch_d),
        .de       (de),
        .em       (em_ctrl),
        .wb_write (wb_write),
        .wb_reg   (wb_reg),
        .stall    (stall),
        .fwd_a_d  (fwd_a_d),
        .fwd_b_d  (fwd_b_d),
        .fwd_a_e  (fwd_a_e),
        .fwd_b_e  (fwd_b_e)
    );

endmodule

//--- verif/mips_tb.sv
`timescale 1ns/100ps
// random program on registers 0-7 with forward branches only; memories answer on the falling edge.
module mips_tb;

    localparam int body_len   = 190;
    localparam int end_idx    = body_len + 14;   // seven setup words, the body, seven final stores.
    localparam int store_lim  = 8000;
    localparam int settle_lim = 40;
    localparam mips_pkg::word_t end_addr = mips_pkg::word_t'(end_idx * 4);

    logic            clk = 1'b0;
    logic            rst;
    mips_pkg::word_t instr;
    mips_pkg::word_t read_data;
    mips_pkg::word_t pc;
    mips_pkg::word_t alu_out;
    mips_pkg::word_t write_data;
    logic            mem_write;

    mips_pkg::word_t imem [256];
    mips_pkg::word_t dmem [128];
    mips_pkg::word_t model_mem [128];
    mips_pkg::word_t model_regs [32];
    mips_pkg::word_t exp_addr [$];
    mips_pkg::word_t exp_data [$];

    mips_core #(
        .reset_pc('0)
    ) i_mips_core (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .alu_out    (alu_out),
        .write_data (write_data),
        .mem_write  (mem_write)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic mips_pkg::word_t fill_word(int k);
        return (mips_pkg::word_t'(k) * 32'h9e3779b9) ^ 32'h5a5a0000;
    endfunction

    function automatic mips_pkg::word_t encode_r(mips_pkg::funct_e f, mips_pkg::reg_addr_t rs,
                                                 mips_pkg::reg_addr_t rt, mips_pkg::reg_addr_t rd);
        return {mips_pkg::op_rtype, rs, rt, rd, 5'b0, f};
    endfunction

    function automatic mips_pkg::word_t encode_i(mips_pkg::opcode_e op, mips_pkg::reg_addr_t rs,
                                                 mips_pkg::reg_addr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t encode_j(logic [25:0] word_idx);
        return {mips_pkg::op_j, word_idx};   // upper pc bits stay zero in this small program.
    endfunction

    function automatic mips_pkg::funct_e pick_funct();
        case ($urandom_range(4))
            0:       return mips_pkg::funct_add;
            1:       return mips_pkg::funct_sub;
            2:       return mips_pkg::funct_and;
            3:       return mips_pkg::funct_or;
            default: return mips_pkg::funct_slt;
        endcase
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_addr(mips_pkg::word_t got, mips_pkg::word_t exp);
        if (got !== exp) abort_run($sformatf("ERROR: alu_out is %h, expected %h", got, exp));
    endtask

    task automatic check_data(mips_pkg::word_t got, mips_pkg::word_t exp);
        if (got !== exp) abort_run($sformatf("ERROR: write_data is %h, expected %h", got, exp));
    endtask

    task automatic check_pc(mips_pkg::word_t got, mips_pkg::word_t exp);
        if (got !== exp) abort_run($sformatf("ERROR: pc is %h, expected %h", got, exp));
    endtask

    task automatic build_program();
        int                  kind;
        int                  tgt;
        logic [15:0]         offs;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t rd;
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = {6'b0, 20'(i * 7919), 6'b0};   // funct 0 is not decoded, so a nop.
        end
        for (int k = 1; k < 8; k++) begin
            imem[8'(k - 1)] = encode_i(mips_pkg::op_addi, 5'd0, 5'(k), 16'($urandom));
            imem[8'(body_len + 6 + k)] = encode_i(mips_pkg::op_sw, 5'd0, 5'(k), 16'(256 + 4 * k));
        end
        for (int i = 7; i < body_len + 7; i++) begin
            rs   = 5'($urandom_range(7));
            rt   = ($urandom_range(3) == 0) ? rs : 5'($urandom_range(7));
            rd   = 5'($urandom_range(7));
            kind = $urandom_range(9);
            offs = 16'(4 * $urandom_range(31));
            tgt  = i + 1 + $urandom_range(6);
            if (tgt > body_len + 7) tgt = body_len + 7;   // the final stores are never skipped.
            case (kind)
                0, 1, 2, 3: imem[8'(i)] = encode_r(pick_funct(), rs, rt, rd);
                4:          imem[8'(i)] = encode_i(mips_pkg::op_addi, rs, rt, 16'($urandom));
                5, 6:       imem[8'(i)] = encode_i(mips_pkg::op_lw, 5'd0, rt, offs);
                7:          imem[8'(i)] = encode_i(mips_pkg::op_sw, 5'd0, rt, offs);
                8:          imem[8'(i)] = encode_i(mips_pkg::op_beq, rs, rt, 16'(tgt - i - 1));
                default:    imem[8'(i)] = encode_j(26'(tgt));
            endcase
        end
        imem[8'(end_idx)] = encode_j(26'(end_idx));
    endtask

    // the reference model runs one instruction at a time with no pipeline.
    task automatic run_model();
        int              idx;
        int              steps;
        mips_pkg::word_t ins;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t simm;
        mips_pkg::word_t addr;
        idx   = 0;
        steps = 0;
        for (int r = 0; r < 32; r++) model_regs[5'(r)] = '0;
        for (int k = 0; k < 128; k++) model_mem[7'(k)] = fill_word(k);
        while (idx != end_idx) begin
            if (steps == 4 * end_idx) abort_run("the model did not reach the end loop");
            ins  = imem[8'(idx)];
            a    = model_regs[ins[25:21]];
            b    = model_regs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = a + simm;
            idx++;
            steps++;
            case (ins[31:26])
                mips_pkg::op_rtype: begin
                    case (ins[5:0])
                        mips_pkg::funct_add: model_regs[ins[15:11]] = a + b;
                        mips_pkg::funct_sub: model_regs[ins[15:11]] = a - b;
                        mips_pkg::funct_and: model_regs[ins[15:11]] = a & b;
                        mips_pkg::funct_or:  model_regs[ins[15:11]] = a | b;
                        mips_pkg::funct_slt:
                            model_regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                mips_pkg::op_addi: model_regs[ins[20:16]] = addr;
                mips_pkg::op_lw:   model_regs[ins[20:16]] = model_mem[addr[8:2]];
                mips_pkg::op_sw: begin
                    model_mem[addr[8:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                mips_pkg::op_beq:  if (a == b) idx += int'($signed(simm));
                mips_pkg::op_j:    idx = int'(ins[25:0]);
                default: ;
            endcase
            model_regs[0] = '0;   // register 0 discards its writes.
        end
    endtask

    // each clock checks a store pulse, updates the data memory and answers the new addresses.
    task automatic advance_cycle();
        @(negedge clk);
        if ($isunknown(mem_write)) abort_run("mem_write is unknown");
        if (mem_write) begin
            if (exp_addr.size() == 0) abort_run("a store was seen that the model does not make");
            check_addr(alu_out, exp_addr.pop_front());
            check_data(write_data, exp_data.pop_front());
            dmem[alu_out[8:2]] = write_data;
        end
        instr     = (pc < 32'd1024) ? imem[pc[9:2]] : '0;
        read_data = dmem[alu_out[8:2]];
    endtask

    initial begin
        int cycles;
        void'($urandom(259));
        rst       = 1'b1;
        instr     = '0;
        read_data = '0;
        for (int k = 0; k < 128; k++) dmem[7'(k)] = fill_word(k);
        build_program();
        run_model();
        for (int i = 0; i < 10; i++) advance_cycle();
        check_pc(pc, '0);
        rst = 1'b0;
        cycles = 0;
        while (exp_addr.size() != 0) begin
            if (cycles == store_lim) abort_run("timeout while waiting for the expected stores");
            advance_cycle();
            cycles++;
        end
        cycles = 0;
        while (pc != end_addr) begin
            if (cycles == settle_lim) abort_run("timeout while waiting for the end loop");
            advance_cycle();
            cycles++;
        end
        // the self jump fetches one word past itself before each redirect.
        for (int i = 0; i < 10; i++) begin
            advance_cycle();
            if (pc != end_addr) check_pc(pc, end_addr + 32'd4);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- project.f
source/mips_pkg.sv
source/mips_fetch.sv
source/mips_decode.sv
source/mips_execute.sv
source/mips_hazard.sv
source/mips_core.sv
verif/mips_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f project.f --top-module mips_tb -o mips_sim
	@out=$$(./obj_dir/mips_sim 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
